//--- filelist.f
+incdir+hw
+incdir+testbench
hw/mask_alu_pkg.sv
hw/mask_uop_decode.sv
hw/mask_bitwise_unit.sv
hw/mask_scan_unit.sv
hw/vid_gen.sv
hw/mask_result_merge.sv
hw/mask_uop_handshake.sv
hw/mask_alu_top.sv
testbench/clk_rst_gen.sv
testbench/tb_mask_alu.sv

//--- hw/mask_alu_params.svh
`ifndef MASK_ALU_PARAMS_SVH
`define MASK_ALU_PARAMS_SVH

// register and scalar widths
`define MASK_VLEN         128
`define MASK_XLEN         32
`define MASK_VLENB        16

// element widths
`define MASK_BYTE_W       8
`define MASK_HWORD_W      16
`define MASK_WORD_W       32

// uop field widths
`define MASK_VSTART_W     7
`define MASK_VL_W         8
`define MASK_UOP_INDEX_W  3
`define MASK_FUNCT6_W     6
`define MASK_FUNCT3_W     3
`define MASK_VS1_W        5

`endif

//--- hw/mask_alu_pkg.sv
`include "mask_alu_params.svh"

package mask_alu_pkg;

  typedef enum logic [`MASK_FUNCT3_W-1:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } funct3_e;

  typedef enum logic [`MASK_FUNCT6_W-1:0] {
    VAND      = 6'b001001,
    VOR       = 6'b001010,
    VXOR      = 6'b001011,
    VWXUNARY0 = 6'b010000,
    VMUNARY0  = 6'b010100,
    VMANDN    = 6'b011000,
    VMAND     = 6'b011001,
    VMOR      = 6'b011010,
    VMXOR     = 6'b011011,
    VMORN     = 6'b011100,
    VMNAND    = 6'b011101,
    VMNOR     = 6'b011110,
    VMXNOR    = 6'b011111
  } funct6_e;

  typedef enum logic [`MASK_VS1_W-1:0] {
    VMSBF  = 5'b00001,
    VMSOF  = 5'b00010,
    VMSIF  = 5'b00011,
    VFIRST = 5'b10001
  } unary_e;

  // vid has the vfirst code, funct6 tells them apart
  parameter unary_e VID = VFIRST;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_AND,
    OP_ANDN,
    OP_OR,
    OP_XOR,
    OP_ORN,
    OP_NAND,
    OP_NOR,
    OP_XNOR,
    OP_SBF,
    OP_SIF,
    OP_SOF,
    OP_FIRST,
    OP_VID
  } mask_op_e;

  typedef enum logic [1:0] {
    MERGE_NONE,
    MERGE_VSTART,
    MERGE_V0
  } merge_e;

endpackage

//--- hw/mask_alu_top.sv
`timescale 1ns/1ps
`include "mask_alu_params.svh"

module mask_alu_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          uop_req,
  input  mask_alu_pkg::funct3_e         funct3,
  input  mask_alu_pkg::funct6_e         funct6,
  input  mask_alu_pkg::unary_e          vs1_opcode,
  input  logic                          vm,
  input  mask_alu_pkg::eew_e            vs2_eew,
  input  mask_alu_pkg::eew_e            vd_eew,
  input  logic [`MASK_VSTART_W-1:0]     vstart,
  input  logic [`MASK_VL_W-1:0]         vl,
  input  logic [`MASK_UOP_INDEX_W-1:0]  uop_index,
  input  logic [`MASK_VLEN-1:0]         vs1_data,
  input  logic [`MASK_VLEN-1:0]         vs2_data,
  input  logic [`MASK_VLEN-1:0]         vd_data,
  input  logic [`MASK_VLEN-1:0]         v0_data,
  input  logic [`MASK_XLEN-1:0]         rs1_data,
  output logic                          uop_ack,
  output logic                          result_valid,
  output logic [`MASK_VLEN-1:0]         result_data
);

  mask_alu_pkg::mask_op_e  op;
  mask_alu_pkg::merge_e    merge;
  logic                    op_legal;
  logic [`MASK_VLEN-1:0]   src1;
  logic [`MASK_VLEN-1:0]   src2;
  logic [`MASK_VLEN-1:0]   logic_result;
  logic [`MASK_VLEN-1:0]   sbf_result;
  logic [`MASK_VLEN-1:0]   sif_result;
  logic [`MASK_VLEN-1:0]   sof_result;
  logic [`MASK_VLEN-1:0]   first_result;
  logic [`MASK_VLEN-1:0]   vid_result;
  logic [`MASK_VLEN-1:0]   merged_result;

  mask_uop_decode i_decode (
    .funct3     (funct3),
    .funct6     (funct6),
    .vs1_opcode (vs1_opcode),
    .vm         (vm),
    .vs2_eew    (vs2_eew),
    .vl         (vl),
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .v0_data    (v0_data),
    .rs1_data   (rs1_data),
    .op         (op),
    .merge      (merge),
    .op_legal   (op_legal),
    .src1       (src1),
    .src2       (src2)
  );

  mask_bitwise_unit i_bitwise (
    .op           (op),
    .src1         (src1),
    .src2         (src2),
    .logic_result (logic_result)
  );

  mask_scan_unit i_scan (
    .src2         (src2),
    .sbf_result   (sbf_result),
    .sif_result   (sif_result),
    .sof_result   (sof_result),
    .first_result (first_result)
  );

  vid_gen i_vid (
    .vd_eew     (vd_eew),
    .uop_index  (uop_index),
    .vid_result (vid_result)
  );

  mask_result_merge i_merge (
    .op            (op),
    .merge         (merge),
    .op_legal      (op_legal),
    .vstart        (vstart),
    .vd_data       (vd_data),
    .v0_data       (v0_data),
    .logic_result  (logic_result),
    .sbf_result    (sbf_result),
    .sif_result    (sif_result),
    .sof_result    (sof_result),
    .first_result  (first_result),
    .vid_result    (vid_result),
    .merged_result (merged_result)
  );

  mask_uop_handshake i_handshake (
    .clk           (clk),
    .rst_n         (rst_n),
    .uop_req       (uop_req),
    .op_legal      (op_legal),
    .merged_result (merged_result),
    .uop_ack       (uop_ack),
    .result_valid  (result_valid),
    .result_data   (result_data)
  );

endmodule

//--- hw/mask_bitwise_unit.sv
`timescale 1ns/1ps
`include "mask_alu_params.svh"

module mask_bitwise_unit (
  input  mask_alu_pkg::mask_op_e  op,
  input  logic [`MASK_VLEN-1:0]   src1,
  input  logic [`MASK_VLEN-1:0]   src2,
  output logic [`MASK_VLEN-1:0]   logic_result
);

  // vs2 is always the left operand
  always_comb begin
    case (op)
      mask_alu_pkg::OP_AND: begin
        logic_result = src2 & src1;
      end
      mask_alu_pkg::OP_ANDN: begin
        logic_result = src2 & ~src1;
      end
      mask_alu_pkg::OP_OR: begin
        logic_result = src2 | src1;
      end
      mask_alu_pkg::OP_XOR: begin
        logic_result = src2 ^ src1;
      end
      mask_alu_pkg::OP_ORN: begin
        logic_result = src2 | ~src1;
      end
      mask_alu_pkg::OP_NAND: begin
        logic_result = ~(src2 & src1);
      end
      mask_alu_pkg::OP_NOR: begin
        logic_result = ~(src2 | src1);
      end
      mask_alu_pkg::OP_XNOR: begin
        logic_result = ~(src2 ^ src1);
      end
      default: begin
        logic_result = '0;
      end
    endcase
  end

endmodule

//--- hw/mask_result_merge.sv
`timescale 1ns/1ps
`include "mask_alu_params.svh"

module mask_result_merge (
  input  mask_alu_pkg::mask_op_e     op,
  input  mask_alu_pkg::merge_e       merge,
  input  logic                       op_legal,
  input  logic [`MASK_VSTART_W-1:0]  vstart,
  input  logic [`MASK_VLEN-1:0]      vd_data,
  input  logic [`MASK_VLEN-1:0]      v0_data,
  input  logic [`MASK_VLEN-1:0]      logic_result,
  input  logic [`MASK_VLEN-1:0]      sbf_result,
  input  logic [`MASK_VLEN-1:0]      sif_result,
  input  logic [`MASK_VLEN-1:0]      sof_result,
  input  logic [`MASK_VLEN-1:0]      first_result,
  input  logic [`MASK_VLEN-1:0]      vid_result,
  output logic [`MASK_VLEN-1:0]      merged_result
);

  logic [`MASK_VLEN-1:0] unit_result;
  logic [`MASK_VLEN-1:0] prefix_mask;

  always_comb begin
    case (op)
      mask_alu_pkg::OP_SBF:   unit_result = sbf_result;
      mask_alu_pkg::OP_SIF:   unit_result = sif_result;
      mask_alu_pkg::OP_SOF:   unit_result = sof_result;
      mask_alu_pkg::OP_FIRST: unit_result = first_result;
      mask_alu_pkg::OP_VID:   unit_result = vid_result;
      mask_alu_pkg::OP_NONE:  unit_result = '0;
      default:                unit_result = logic_result;
    endcase
  end

  // ones below vstart
  assign prefix_mask = ((`MASK_VLEN)'(1) << vstart) - (`MASK_VLEN)'(1);

  always_comb begin
    if (!op_legal) begin
      merged_result = '0;
    end else begin
      case (merge)
        mask_alu_pkg::MERGE_VSTART: begin
          merged_result = (unit_result & ~prefix_mask) | (vd_data & prefix_mask);
        end
        mask_alu_pkg::MERGE_V0: begin
          // inactive bits keep vd
          merged_result = (unit_result & v0_data) | (vd_data & ~v0_data);
        end
        default: begin
          merged_result = unit_result;
        end
      endcase
    end
  end

endmodule

//--- hw/mask_scan_unit.sv
`timescale 1ns/1ps
`include "mask_alu_params.svh"

module mask_scan_unit (
  input  logic [`MASK_VLEN-1:0]  src2,
  output logic [`MASK_VLEN-1:0]  sbf_result,
  output logic [`MASK_VLEN-1:0]  sif_result,
  output logic [`MASK_VLEN-1:0]  sof_result,
  output logic [`MASK_VLEN-1:0]  first_result
);

  localparam int IDX_W = $clog2(`MASK_VLEN);

  logic [`MASK_VLEN-1:0] src2_sub1;
  logic [`MASK_VLEN-1:0] sif_raw;
  logic                  src_zero;
  logic [IDX_W-1:0]      first_idx;

  // subtracting one flips the lowest set bit and everything below it
  assign src2_sub1 = src2 - (`MASK_VLEN)'(1);
  assign sif_raw   = src2 ^ src2_sub1;
  assign src_zero  = ~|src2;

  assign sof_result = src2 & ~src2_sub1;

  // a zero source already gives all ones here
  assign sif_result = sif_raw;

  assign sbf_result = src_zero ? {`MASK_VLEN{1'b1}} : {1'b0, sif_raw[`MASK_VLEN-1:1]};

  // sof is one-hot, so or-ing the indices encodes it
  always_comb begin
    first_idx = '0;
    for (int i = 0; i < `MASK_VLEN; i++) begin
      if (sof_result[i]) begin
        first_idx = first_idx | IDX_W'(i);
      end
    end
  end

  assign first_result = src_zero ? {`MASK_VLEN{1'b1}} : (`MASK_VLEN)'(first_idx);

endmodule

//--- hw/mask_uop_decode.sv
`timescale 1ns/1ps
`include "mask_alu_params.svh"

module mask_uop_decode (
  input  mask_alu_pkg::funct3_e   funct3,
  input  mask_alu_pkg::funct6_e   funct6,
  input  mask_alu_pkg::unary_e    vs1_opcode,
  input  logic                    vm,
  input  mask_alu_pkg::eew_e      vs2_eew,
  input  logic [`MASK_VL_W-1:0]   vl,
  input  logic [`MASK_VLEN-1:0]   vs1_data,
  input  logic [`MASK_VLEN-1:0]   vs2_data,
  input  logic [`MASK_VLEN-1:0]   v0_data,
  input  logic [`MASK_XLEN-1:0]   rs1_data,
  output mask_alu_pkg::mask_op_e  op,
  output mask_alu_pkg::merge_e    merge,
  output logic                    op_legal,
  output logic [`MASK_VLEN-1:0]   src1,
  output logic [`MASK_VLEN-1:0]   src2
);

  logic [`MASK_VLEN-1:0] tail_mask;
  logic [`MASK_VLEN-1:0] active_mask;
  logic [`MASK_VLEN-1:0] scalar_rep;

  // body elements lie below vl
  always_comb begin
    for (int i = 0; i < `MASK_VLEN; i++) begin
      tail_mask[i] = vl > (`MASK_VL_W)'(i);
    end
  end

  assign active_mask = vm ? {`MASK_VLEN{1'b1}} : v0_data;

  // scalar or immediate spread at the source element width
  always_comb begin
    case (vs2_eew)
      mask_alu_pkg::EEW8: begin
        scalar_rep = {(`MASK_VLEN/`MASK_BYTE_W){rs1_data[`MASK_BYTE_W-1:0]}};
      end
      mask_alu_pkg::EEW16: begin
        scalar_rep = {(`MASK_VLEN/`MASK_HWORD_W){rs1_data[`MASK_HWORD_W-1:0]}};
      end
      mask_alu_pkg::EEW32: begin
        scalar_rep = {(`MASK_VLEN/`MASK_WORD_W){rs1_data[`MASK_WORD_W-1:0]}};
      end
      default: begin
        scalar_rep = '0;
      end
    endcase
  end

  always_comb begin
    op    = mask_alu_pkg::OP_NONE;
    merge = mask_alu_pkg::MERGE_NONE;
    src1  = (funct3 == mask_alu_pkg::OPIVV || funct3 == mask_alu_pkg::OPMVV) ?
            vs1_data : scalar_rep;
    src2  = vs2_data;

    case (funct3)
      mask_alu_pkg::OPIVV,
      mask_alu_pkg::OPIVX,
      mask_alu_pkg::OPIVI: begin
        case (funct6)
          mask_alu_pkg::VAND: op = mask_alu_pkg::OP_AND;
          mask_alu_pkg::VOR:  op = mask_alu_pkg::OP_OR;
          mask_alu_pkg::VXOR: op = mask_alu_pkg::OP_XOR;
          default:            op = mask_alu_pkg::OP_NONE;
        endcase
      end
      mask_alu_pkg::OPMVV: begin
        case (funct6)
          mask_alu_pkg::VMANDN: op = mask_alu_pkg::OP_ANDN;
          mask_alu_pkg::VMAND:  op = mask_alu_pkg::OP_AND;
          mask_alu_pkg::VMOR:   op = mask_alu_pkg::OP_OR;
          mask_alu_pkg::VMXOR:  op = mask_alu_pkg::OP_XOR;
          mask_alu_pkg::VMORN:  op = mask_alu_pkg::OP_ORN;
          mask_alu_pkg::VMNAND: op = mask_alu_pkg::OP_NAND;
          mask_alu_pkg::VMNOR:  op = mask_alu_pkg::OP_NOR;
          mask_alu_pkg::VMXNOR: op = mask_alu_pkg::OP_XNOR;
          mask_alu_pkg::VWXUNARY0: begin
            if (vs1_opcode == mask_alu_pkg::VFIRST) begin
              op   = mask_alu_pkg::OP_FIRST;
              src2 = vs2_data & tail_mask & active_mask;
            end
          end
          mask_alu_pkg::VMUNARY0: begin
            case (vs1_opcode)
              mask_alu_pkg::VMSBF: op = mask_alu_pkg::OP_SBF;
              mask_alu_pkg::VMSIF: op = mask_alu_pkg::OP_SIF;
              mask_alu_pkg::VMSOF: op = mask_alu_pkg::OP_SOF;
              mask_alu_pkg::VID:   op = mask_alu_pkg::OP_VID;
              default:             op = mask_alu_pkg::OP_NONE;
            endcase
          end
          default: op = mask_alu_pkg::OP_NONE;
        endcase

        // mask-register logicals keep the prefix below vstart
        if (op inside {[mask_alu_pkg::OP_AND:mask_alu_pkg::OP_XNOR]}) begin
          merge = mask_alu_pkg::MERGE_VSTART;
        end
        if (op inside {mask_alu_pkg::OP_SBF, mask_alu_pkg::OP_SIF, mask_alu_pkg::OP_SOF}) begin
          src2  = vs2_data & active_mask;
          merge = vm ? mask_alu_pkg::MERGE_NONE : mask_alu_pkg::MERGE_V0;
        end
      end
      default: op = mask_alu_pkg::OP_NONE;
    endcase

    // mask logicals are only defined unmasked
    op_legal = (op != mask_alu_pkg::OP_NONE) && (vm || merge != mask_alu_pkg::MERGE_VSTART);
  end

endmodule

//--- hw/mask_uop_handshake.sv
`timescale 1ns/1ps
`include "mask_alu_params.svh"

module mask_uop_handshake (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   uop_req,
  input  logic                   op_legal,
  input  logic [`MASK_VLEN-1:0]  merged_result,
  output logic                   uop_ack,
  output logic                   result_valid,
  output logic [`MASK_VLEN-1:0]  result_data
);

  logic capture;

  // new request seen while idle
  assign capture = uop_req && !uop_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_ack <= 1'b0;
    end else if (capture) begin
      uop_ack <= 1'b1;
    end else if (!uop_req) begin
      uop_ack <= 1'b0;
    end
  end

  // result holds until the next capture
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result_data  <= '0;
    end else if (capture) begin
      result_valid <= op_legal;
      result_data  <= merged_result;
    end
  end

endmodule

//--- hw/vid_gen.sv
`timescale 1ns/1ps
`include "mask_alu_params.svh"

module vid_gen (
  input  mask_alu_pkg::eew_e             vd_eew,
  input  logic [`MASK_UOP_INDEX_W-1:0]   uop_index,
  output logic [`MASK_VLEN-1:0]          vid_result
);

  // elements per register at each width
  localparam int E8  = `MASK_VLENB;
  localparam int E16 = `MASK_VLEN / `MASK_HWORD_W;
  localparam int E32 = `MASK_VLEN / `MASK_WORD_W;

  logic [`MASK_VLEN-1:0] vid8;
  logic [`MASK_VLEN-1:0] vid16;
  logic [`MASK_VLEN-1:0] vid32;

  genvar j;

  generate
    for (j = 0; j < E8; j++) begin : g_vid8
      assign vid8[j*`MASK_BYTE_W +: `MASK_BYTE_W] = (`MASK_BYTE_W)'(uop_index * E8 + j);
    end
    for (j = 0; j < E16; j++) begin : g_vid16
      assign vid16[j*`MASK_HWORD_W +: `MASK_HWORD_W] = (`MASK_HWORD_W)'(uop_index * E16 + j);
    end
    for (j = 0; j < E32; j++) begin : g_vid32
      assign vid32[j*`MASK_WORD_W +: `MASK_WORD_W] = (`MASK_WORD_W)'(uop_index * E32 + j);
    end
  endgenerate

  always_comb begin
    case (vd_eew)
      mask_alu_pkg::EEW8:  vid_result = vid8;
      mask_alu_pkg::EEW16: vid_result = vid16;
      mask_alu_pkg::EEW32: vid_result = vid32;
      default:             vid_result = '0;
    endcase
  end

endmodule

//--- testbench/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 10;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // reset low for the first few rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- testbench/mask_alu_ref.svh
`ifndef MASK_ALU_REF_SVH
`define MASK_ALU_REF_SVH

function automatic int ref_width(input mask_alu_pkg::eew_e e);
  case (e)
    mask_alu_pkg::EEW8:  return 8;
    mask_alu_pkg::EEW16: return 16;
    default:             return 32;
  endcase
endfunction

// one bit of vs2 combined with one bit of the first source
function automatic logic ref_bit(input mask_alu_pkg::funct6_e f6, input logic b2, input logic b1);
  case (f6)
    mask_alu_pkg::VAND, mask_alu_pkg::VMAND: return b2 & b1;
    mask_alu_pkg::VMANDN:                    return b2 & ~b1;
    mask_alu_pkg::VOR, mask_alu_pkg::VMOR:   return b2 | b1;
    mask_alu_pkg::VMORN:                     return b2 | ~b1;
    mask_alu_pkg::VXOR, mask_alu_pkg::VMXOR: return b2 ^ b1;
    mask_alu_pkg::VMNAND:                    return ~(b2 & b1);
    mask_alu_pkg::VMNOR:                     return ~(b2 | b1);
    mask_alu_pkg::VMXNOR:                    return ~(b2 ^ b1);
    default:                                 return 1'b0;
  endcase
endfunction

function automatic logic ref_legal(
  input mask_alu_pkg::funct3_e f3,
  input mask_alu_pkg::funct6_e f6,
  input mask_alu_pkg::unary_e  opc,
  input logic                  vm_b
);
  case (f3)
    mask_alu_pkg::OPIVV, mask_alu_pkg::OPIVX, mask_alu_pkg::OPIVI: begin
      return f6 inside {mask_alu_pkg::VAND, mask_alu_pkg::VOR, mask_alu_pkg::VXOR};
    end
    mask_alu_pkg::OPMVV: begin
      case (f6)
        mask_alu_pkg::VMANDN, mask_alu_pkg::VMAND, mask_alu_pkg::VMOR, mask_alu_pkg::VMXOR,
        mask_alu_pkg::VMORN, mask_alu_pkg::VMNAND, mask_alu_pkg::VMNOR, mask_alu_pkg::VMXNOR: begin
          return vm_b;
        end
        mask_alu_pkg::VWXUNARY0: return opc == mask_alu_pkg::VFIRST;
        mask_alu_pkg::VMUNARY0: begin
          return opc inside {mask_alu_pkg::VMSBF, mask_alu_pkg::VMSIF,
                             mask_alu_pkg::VMSOF, mask_alu_pkg::VID};
        end
        default: return 1'b0;
      endcase
    end
    default: return 1'b0;
  endcase
endfunction

function automatic logic [`MASK_VLEN-1:0] ref_result(
  input mask_alu_pkg::funct3_e f3,
  input mask_alu_pkg::funct6_e f6,
  input mask_alu_pkg::unary_e  opc,
  input logic                  vm_b,
  input mask_alu_pkg::eew_e    s_eew,
  input mask_alu_pkg::eew_e    d_eew,
  input int                    vstart_n,
  input int                    vl_n,
  input int                    idx_n,
  input logic [`MASK_VLEN-1:0] a1,
  input logic [`MASK_VLEN-1:0] a2,
  input logic [`MASK_VLEN-1:0] old_vd,
  input logic [`MASK_VLEN-1:0] mask0,
  input logic [`MASK_XLEN-1:0] scalar
);
  logic [`MASK_VLEN-1:0] res;
  logic                  found;
  logic                  act;
  logic                  opnd;
  int                    w;
  int                    val;
  res   = '0;
  found = 1'b0;
  if (!ref_legal(f3, f6, opc, vm_b)) begin
    return '0;
  end
  if (f3 != mask_alu_pkg::OPMVV) begin
    w = ref_width(s_eew);
    for (int i = 0; i < `MASK_VLEN; i++) begin
      opnd   = (f3 == mask_alu_pkg::OPIVV) ? a1[i] : scalar[i % w];
      res[i] = ref_bit(f6, a2[i], opnd);
    end
  end else if (f6 == mask_alu_pkg::VWXUNARY0) begin
    // no active set bit leaves all ones
    res = '1;
    for (int i = 0; i < `MASK_VLEN; i++) begin
      act = (i < vl_n) && (vm_b || mask0[i]);
      if (!found && act && a2[i]) begin
        res   = (`MASK_VLEN)'(i);
        found = 1'b1;
      end
    end
  end else if (f6 == mask_alu_pkg::VMUNARY0 && opc == mask_alu_pkg::VID) begin
    w = ref_width(d_eew);
    for (int j = 0; j < `MASK_VLEN / w; j++) begin
      val = idx_n * (`MASK_VLEN / w) + j;
      for (int b = 0; b < w; b++) begin
        res[j*w + b] = val[b];
      end
    end
  end else if (f6 == mask_alu_pkg::VMUNARY0) begin
    for (int i = 0; i < `MASK_VLEN; i++) begin
      act = vm_b || mask0[i];
      if (!act) begin
        res[i] = old_vd[i];
      end else if (found) begin
        res[i] = 1'b0;
      end else if (a2[i]) begin
        res[i] = (opc != mask_alu_pkg::VMSBF);
        found  = 1'b1;
      end else begin
        res[i] = (opc != mask_alu_pkg::VMSOF);
      end
    end
  end else begin
    // mask logicals, prefix below vstart untouched
    for (int i = 0; i < `MASK_VLEN; i++) begin
      res[i] = (i < vstart_n) ? old_vd[i] : ref_bit(f6, a2[i], a1[i]);
    end
  end
  return res;
endfunction

`endif

//--- testbench/tb_mask_alu.sv
`timescale 1ns/1ps
`include "mask_alu_params.svh"

module tb_mask_alu;

  // uops per test, kept in step with the loops below
  localparam int N_BITWISE  = 54;
  localparam int N_MLOGIC   = 32;
  localparam int N_SETFIRST = 24;
  localparam int N_VFIRST   = 12;
  localparam int N_VID      = 24;
  localparam int N_UOPS     = N_BITWISE + N_MLOGIC + N_SETFIRST + N_VFIRST + N_VID;
  localparam int TIMEOUT_CYCLES = N_UOPS * 6 + 50;
  localparam int ACK_WAIT = 8;

  logic                          clk;
  logic                          rst_n;
  logic                          uop_req;
  mask_alu_pkg::funct3_e         funct3;
  mask_alu_pkg::funct6_e         funct6;
  mask_alu_pkg::unary_e          vs1_opcode;
  logic                          vm;
  mask_alu_pkg::eew_e            vs2_eew;
  mask_alu_pkg::eew_e            vd_eew;
  logic [`MASK_VSTART_W-1:0]     vstart;
  logic [`MASK_VL_W-1:0]         vl;
  logic [`MASK_UOP_INDEX_W-1:0]  uop_index;
  logic [`MASK_VLEN-1:0]         vs1_data;
  logic [`MASK_VLEN-1:0]         vs2_data;
  logic [`MASK_VLEN-1:0]         vd_data;
  logic [`MASK_VLEN-1:0]         v0_data;
  logic [`MASK_XLEN-1:0]         rs1_data;
  logic                          uop_ack;
  logic                          result_valid;
  logic [`MASK_VLEN-1:0]         result_data;

  integer                seed;
  int                    errors;
  int                    checks;
  int                    uops_done;
  int                    cycle_count;
  logic [`MASK_VLEN-1:0] exp_data;
  logic                  exp_valid;
  logic                  ack_prev;
  int                    req_cycles;
  int                    drop_cycles;

  mask_alu_pkg::eew_e eews [3] = '{mask_alu_pkg::EEW8, mask_alu_pkg::EEW16, mask_alu_pkg::EEW32};

  `include "mask_alu_ref.svh"

  clk_rst_gen i_clk_rst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mask_alu_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_req      (uop_req),
    .funct3       (funct3),
    .funct6       (funct6),
    .vs1_opcode   (vs1_opcode),
    .vm           (vm),
    .vs2_eew      (vs2_eew),
    .vd_eew       (vd_eew),
    .vstart       (vstart),
    .vl           (vl),
    .uop_index    (uop_index),
    .vs1_data     (vs1_data),
    .vs2_data     (vs2_data),
    .vd_data      (vd_data),
    .v0_data      (v0_data),
    .rs1_data     (rs1_data),
    .uop_ack      (uop_ack),
    .result_valid (result_valid),
    .result_data  (result_data)
  );

  function automatic logic [`MASK_VLEN-1:0] rand_vec();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic [`MASK_VL_W-1:0] rand_vl();
    return (`MASK_VL_W)'($unsigned($random(seed)) % (`MASK_VLEN + 1));
  endfunction

  // one full four-phase transfer
  task automatic issue_uop(
    input mask_alu_pkg::funct3_e f3,
    input mask_alu_pkg::funct6_e f6,
    input mask_alu_pkg::unary_e  opc,
    input logic                  vm_i,
    input mask_alu_pkg::eew_e    s_eew,
    input mask_alu_pkg::eew_e    d_eew,
    input logic [`MASK_VSTART_W-1:0]    vstart_i,
    input logic [`MASK_VL_W-1:0]        vl_i,
    input logic [`MASK_UOP_INDEX_W-1:0] idx_i,
    input logic [`MASK_VLEN-1:0] vs1_i,
    input logic [`MASK_VLEN-1:0] vs2_i,
    input logic [`MASK_VLEN-1:0] vd_i,
    input logic [`MASK_VLEN-1:0] v0_i,
    input logic [`MASK_XLEN-1:0] rs1_i
  );
    int waited;
    exp_valid = ref_legal(f3, f6, opc, vm_i);
    exp_data  = ref_result(f3, f6, opc, vm_i, s_eew, d_eew, int'(vstart_i), int'(vl_i),
                           int'(idx_i), vs1_i, vs2_i, vd_i, v0_i, rs1_i);
    @(posedge clk);
    funct3     <= f3;
    funct6     <= f6;
    vs1_opcode <= opc;
    vm         <= vm_i;
    vs2_eew    <= s_eew;
    vd_eew     <= d_eew;
    vstart     <= vstart_i;
    vl         <= vl_i;
    uop_index  <= idx_i;
    vs1_data   <= vs1_i;
    vs2_data   <= vs2_i;
    vd_data    <= vd_i;
    v0_data    <= v0_i;
    rs1_data   <= rs1_i;
    uop_req    <= 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!uop_ack && waited < ACK_WAIT);
    assert (uop_ack) else begin
      $display("uop_ack did not rise within %0d cycles of the request", ACK_WAIT);
      errors++;
    end
    @(posedge clk);
    uop_req <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (uop_ack && waited < ACK_WAIT);
    assert (!uop_ack) else begin
      $display("uop_ack did not fall within %0d cycles of the request dropping", ACK_WAIT);
      errors++;
    end
    uops_done++;
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("test %-10s done, %0d errors", name, errors - err_start);
  endtask

  task automatic check_idle();
    int err_start;
    err_start = errors;
    @(negedge clk);
    assert (uop_ack === 1'b0) else begin
      $display("Fail at %0t: uop_ack expected 0, got %b", $time, uop_ack);
      errors++;
    end
    assert (result_valid === 1'b0) else begin
      $display("Fail at %0t: result_valid expected 0, got %b", $time, result_valid);
      errors++;
    end
    assert (result_data === '0) else begin
      $display("Fail at %0t: result_data expected 0, got %h", $time, result_data);
      errors++;
    end
    report_test("idle", err_start);
  endtask

  task automatic test_bitwise();
    mask_alu_pkg::funct6_e ops [3] = '{mask_alu_pkg::VAND, mask_alu_pkg::VOR, mask_alu_pkg::VXOR};
    mask_alu_pkg::funct3_e forms [3] = '{mask_alu_pkg::OPIVV, mask_alu_pkg::OPIVX,
                                         mask_alu_pkg::OPIVI};
    int err_start;
    err_start = errors;
    for (int o = 0; o < 3; o++) begin
      for (int f = 0; f < 3; f++) begin
        for (int e = 0; e < 3; e++) begin
          for (int r = 0; r < 2; r++) begin
            issue_uop(forms[f], ops[o], mask_alu_pkg::VFIRST, 1'($random(seed)), eews[e],
                      eews[e], '0, rand_vl(), '0, rand_vec(), rand_vec(), rand_vec(),
                      rand_vec(), $random(seed));
          end
        end
      end
    end
    report_test("bitwise", err_start);
  endtask

  task automatic test_mask_logic();
    mask_alu_pkg::funct6_e ops [8] = '{mask_alu_pkg::VMANDN, mask_alu_pkg::VMAND,
                                       mask_alu_pkg::VMOR, mask_alu_pkg::VMXOR,
                                       mask_alu_pkg::VMORN, mask_alu_pkg::VMNAND,
                                       mask_alu_pkg::VMNOR, mask_alu_pkg::VMXNOR};
    int err_start;
    err_start = errors;
    for (int o = 0; o < 8; o++) begin
      for (int r = 0; r < 3; r++) begin
        issue_uop(mask_alu_pkg::OPMVV, ops[o], mask_alu_pkg::VFIRST, 1'b1, mask_alu_pkg::EEW8,
                  mask_alu_pkg::EEW8, (`MASK_VSTART_W)'($random(seed)), rand_vl(), '0,
                  rand_vec(), rand_vec(), rand_vec(), rand_vec(), $random(seed));
      end
    end
    // masked form is illegal for these
    for (int o = 0; o < 8; o++) begin
      issue_uop(mask_alu_pkg::OPMVV, ops[o], mask_alu_pkg::VFIRST, 1'b0, mask_alu_pkg::EEW8,
                mask_alu_pkg::EEW8, (`MASK_VSTART_W)'($random(seed)), rand_vl(), '0,
                rand_vec(), rand_vec(), rand_vec(), rand_vec(), $random(seed));
    end
    report_test("mask_logic", err_start);
  endtask

  task automatic test_set_first();
    mask_alu_pkg::unary_e ops [3] = '{mask_alu_pkg::VMSBF, mask_alu_pkg::VMSIF,
                                      mask_alu_pkg::VMSOF};
    logic [`MASK_VLEN-1:0] vs2_v;
    int err_start;
    err_start = errors;
    for (int o = 0; o < 3; o++) begin
      for (int v = 0; v < 2; v++) begin
        for (int r = 0; r < 4; r++) begin
          vs2_v = (r == 0) ? '0 : (rand_vec() & rand_vec());
          issue_uop(mask_alu_pkg::OPMVV, mask_alu_pkg::VMUNARY0, ops[o], 1'(v),
                    mask_alu_pkg::EEW8, mask_alu_pkg::EEW8, '0, rand_vl(), '0, rand_vec(),
                    vs2_v, rand_vec(), rand_vec(), $random(seed));
        end
      end
    end
    report_test("set_first", err_start);
  endtask

  task automatic test_vfirst();
    logic [`MASK_VLEN-1:0] vs2_v;
    logic [`MASK_VLEN-1:0] v0_v;
    logic [`MASK_VL_W-1:0] vl_v;
    logic                  vm_v;
    int err_start;
    err_start = errors;
    for (int r = 0; r < N_VFIRST; r++) begin
      vs2_v = rand_vec() & rand_vec() & rand_vec();
      v0_v  = rand_vec();
      vl_v  = rand_vl();
      vm_v  = 1'($random(seed));
      // first few leave nothing active
      if (r == 0) begin
        vs2_v = '0;
      end
      if (r == 1) begin
        vl_v = '0;
      end
      if (r == 2) begin
        vm_v = 1'b0;
        v0_v = '0;
      end
      issue_uop(mask_alu_pkg::OPMVV, mask_alu_pkg::VWXUNARY0, mask_alu_pkg::VFIRST, vm_v,
                mask_alu_pkg::EEW8, mask_alu_pkg::EEW8, '0, vl_v, '0, rand_vec(), vs2_v,
                rand_vec(), v0_v, $random(seed));
    end
    report_test("vfirst", err_start);
  endtask

  task automatic test_vid();
    int err_start;
    err_start = errors;
    for (int e = 0; e < 3; e++) begin
      for (int idx = 0; idx < 8; idx++) begin
        issue_uop(mask_alu_pkg::OPMVV, mask_alu_pkg::VMUNARY0, mask_alu_pkg::VID, 1'b1,
                  mask_alu_pkg::EEW8, eews[e], '0, rand_vl(), (`MASK_UOP_INDEX_W)'(idx),
                  rand_vec(), rand_vec(), rand_vec(), rand_vec(), $random(seed));
      end
    end
    report_test("vid", err_start);
  endtask

  // checks the captured result and the ack timing
  always @(negedge clk) begin
    if (rst_n) begin
      if (uop_ack && !ack_prev) begin
        checks++;
        assert (req_cycles == 1) else begin
          $display("Fail at %0t: uop_ack rise latency expected 1, got %0d", $time, req_cycles);
          errors++;
        end
        assert (result_valid === exp_valid) else begin
          $display("Fail at %0t: result_valid expected %b, got %b", $time, exp_valid,
                   result_valid);
          errors++;
        end
        assert (result_data === exp_data) else begin
          $display("Fail at %0t: result_data expected %h, got %h", $time, exp_data,
                   result_data);
          errors++;
        end
        req_cycles = 0;
      end
      if (!uop_ack && ack_prev) begin
        assert (drop_cycles == 1) else begin
          $display("Fail at %0t: uop_ack fall latency expected 1, got %0d", $time, drop_cycles);
          errors++;
        end
        drop_cycles = 0;
      end
      if (uop_req && !uop_ack) begin
        req_cycles++;
      end
      if (!uop_req && uop_ack) begin
        drop_cycles++;
      end
      ack_prev = uop_ack;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    seed        = 32'h5396_ee35;
    errors      = 0;
    checks      = 0;
    uops_done   = 0;
    cycle_count = 0;
    ack_prev    = 1'b0;
    req_cycles  = 0;
    drop_cycles = 0;
    exp_data    = '0;
    exp_valid   = 1'b0;
    uop_req    <= 1'b0;
    funct3     <= mask_alu_pkg::OPIVV;
    funct6     <= mask_alu_pkg::VAND;
    vs1_opcode <= mask_alu_pkg::VFIRST;
    vm         <= 1'b1;
    vs2_eew    <= mask_alu_pkg::EEW8;
    vd_eew     <= mask_alu_pkg::EEW8;
    vstart     <= '0;
    vl         <= '0;
    uop_index  <= '0;
    vs1_data   <= '0;
    vs2_data   <= '0;
    vd_data    <= '0;
    v0_data    <= '0;
    rs1_data   <= '0;
    @(posedge rst_n);
    check_idle();
    test_bitwise();
    test_mask_logic();
    test_set_first();
    test_vfirst();
    test_vid();
    $display("summary: %0d uops, %0d result checks, %0d errors", uops_done, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
